// File: source/lsu_pkg.sv
package lsu_pkg;

    localparam int ROB_SIZE = 32;

    typedef logic [31:0] word_t;
    typedef logic [$clog2(ROB_SIZE)-1:0] rob_num_t;
    typedef logic [16:0] offset_t;
    typedef logic [3:0] strb_t;

    // loads first, stores last
    typedef enum logic [2:0] {
        OP_LB,
        OP_LBU,
        OP_LH,
        OP_LHU,
        OP_LW,
        OP_SB,
        OP_SH,
        OP_SW
    } mem_op_e;

    typedef enum logic [1:0] {
        EXC_NONE,
        EXC_LOAD_ADDR,
        EXC_STORE_ADDR
    } exc_code_e;

endpackage

// File: source/cache_pkg.sv
package cache_pkg;

    localparam int DCACHE_SETS = 64;
    localparam int DCACHE_WAYS = 2;

    // one-word lines, so the index sits right above the byte offset
    localparam int INDEX_LSB = 2;
    localparam int TAG_LSB   = 8;

    // slots the memory grants at reset
    localparam int MEM_CREDITS = 4;

    typedef logic [$clog2(DCACHE_SETS)-1:0] index_t;
    typedef logic [31-TAG_LSB:0] tag_t;
    typedef logic [DCACHE_WAYS-1:0] way_sel_t;   // one-hot
    typedef logic [2:0] credit_cnt_t;

endpackage

// File: source/lsu_agu.sv
`timescale 1ns/10ps

module lsu_agu (
    input  logic              clk,
    input  logic              resetn,
    input  logic              advance,
    input  logic              sel_valid,
    input  lsu_pkg::mem_op_e  sel_op,
    input  lsu_pkg::word_t    sel_base,
    input  lsu_pkg::offset_t  sel_offset,
    input  lsu_pkg::word_t    sel_store_data,
    input  lsu_pkg::rob_num_t sel_dest,
    output logic              iss_valid,
    output logic              mem_valid,
    output lsu_pkg::mem_op_e  mem_op,
    output lsu_pkg::word_t    mem_addr,
    output lsu_pkg::word_t    mem_wdata,
    output lsu_pkg::strb_t    mem_wstrb,
    output lsu_pkg::rob_num_t mem_dest,
    output logic              mem_misaligned
);

    lsu_pkg::mem_op_e  iss_op;
    lsu_pkg::word_t    iss_base;
    lsu_pkg::offset_t  iss_offset;
    lsu_pkg::word_t    iss_data;
    lsu_pkg::rob_num_t iss_dest;
    lsu_pkg::word_t    addr;
    lsu_pkg::word_t    wdata;
    lsu_pkg::strb_t    wstrb;
    logic              misaligned;
    logic              iss_load;

    // takes a new item whenever the slot is free or draining
    assign iss_load = !iss_valid || advance;

    always_ff @(posedge clk) begin
        if (!resetn) begin
            iss_valid <= 1'b0;
            mem_valid <= 1'b0;
        end else begin
            if (iss_load)
                iss_valid <= sel_valid;
            if (advance)
                mem_valid <= iss_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (iss_load) begin
            iss_op     <= sel_op;
            iss_base   <= sel_base;
            iss_offset <= sel_offset;
            iss_data   <= sel_store_data;
            iss_dest   <= sel_dest;
        end
        if (advance) begin
            mem_op         <= iss_op;
            mem_addr       <= addr;
            mem_wdata      <= wdata;
            mem_wstrb      <= wstrb;
            mem_dest       <= iss_dest;
            mem_misaligned <= misaligned;
        end
    end

    assign addr = iss_base + {{15{iss_offset[16]}}, iss_offset};

    // store lanes and strobe, plus alignment check
    always_comb begin
        wdata      = iss_data;
        wstrb      = 4'b0000;
        misaligned = 1'b0;
        case (iss_op)
            lsu_pkg::OP_SB: begin
                wdata = iss_data << {addr[1:0], 3'b000};
                wstrb = 4'b0001 << addr[1:0];
            end
            lsu_pkg::OP_SH: begin
                wdata      = addr[1] ? {iss_data[15:0], 16'b0} : iss_data;
                wstrb      = addr[1] ? 4'b1100 : 4'b0011;
                misaligned = addr[0];
            end
            lsu_pkg::OP_SW: begin
                wstrb      = 4'b1111;
                misaligned = |addr[1:0];
            end
            lsu_pkg::OP_LH, lsu_pkg::OP_LHU: misaligned = addr[0];
            lsu_pkg::OP_LW:                  misaligned = |addr[1:0];
            default: ;
        endcase
    end

endmodule

// File: source/lsu_ctrl.sv
`timescale 1ns/10ps

module lsu_ctrl (
    input  logic                clk,
    input  logic                resetn,
    input  logic                iss_valid,
    input  logic                mem_valid,
    input  lsu_pkg::mem_op_e    mem_op,
    input  logic                mem_misaligned,
    input  cache_pkg::way_sel_t hit_way,
    input  cache_pkg::way_sel_t victim_way,
    input  logic                mem_credit,
    input  logic                mem_rvalid,
    output logic                issue_busy,
    output logic                advance,
    output logic                mem_req_valid,
    output logic                mem_req_write,
    output logic                fill_en,
    output cache_pkg::way_sel_t fill_way,
    output logic                store_hit_en,
    output logic                lru_touch,
    output logic                wb_take,
    output logic                wb_use_fill,
    output logic                wb_is_store
);

    typedef enum logic [1:0] {
        IDLE,
        MISS_REQ,
        MISS_WAIT,
        FILL_WRITE
    } state_e;

    state_e                 state;
    state_e                 state_nxt;
    cache_pkg::credit_cnt_t credits;
    logic                   have_credit;
    logic                   is_store;
    logic                   hit;
    logic                   checked;     // aligned item in mem stage, not yet in a miss
    logic                   load_hit;
    logic                   store_req;
    logic                   read_req;
    logic                   complete;

    assign is_store    = mem_op inside {lsu_pkg::OP_SB, lsu_pkg::OP_SH, lsu_pkg::OP_SW};
    assign hit         = |hit_way;
    assign have_credit = credits != '0;
    assign checked     = (state == IDLE) && mem_valid && !mem_misaligned;

    assign load_hit  = checked && !is_store && hit;
    assign store_req = checked && is_store && have_credit;
    assign read_req  = (state == MISS_REQ) && have_credit;

    // mem stage retires this cycle
    always_comb begin
        case (state)
            IDLE:       complete = mem_valid && (mem_misaligned || load_hit || store_req);
            FILL_WRITE: complete = 1'b1;
            default:    complete = 1'b0;
        endcase
    end

    assign advance    = !mem_valid || complete;
    assign issue_busy = iss_valid && !advance;

    assign mem_req_valid = store_req || read_req;
    assign mem_req_write = store_req;

    assign fill_en      = (state == MISS_WAIT) && mem_rvalid;
    assign fill_way     = victim_way;    // set is untouched during a miss
    assign store_hit_en = store_req && hit;    // write-through, no allocate
    assign lru_touch    = load_hit || (store_req && hit);

    assign wb_take     = complete;
    assign wb_use_fill = state == FILL_WRITE;
    assign wb_is_store = is_store;

    always_comb begin
        state_nxt = state;
        case (state)
            IDLE: begin
                if (checked && !is_store && !hit)
                    state_nxt = MISS_REQ;
            end
            MISS_REQ: begin
                if (have_credit)
                    state_nxt = MISS_WAIT;
            end
            MISS_WAIT: begin
                if (mem_rvalid)
                    state_nxt = FILL_WRITE;
            end
            default: state_nxt = IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!resetn) begin
            state   <= IDLE;
            credits <= cache_pkg::credit_cnt_t'(cache_pkg::MEM_CREDITS);
        end else begin
            state   <= state_nxt;
            credits <= credits + cache_pkg::credit_cnt_t'(mem_credit)
                     - cache_pkg::credit_cnt_t'(mem_req_valid);
        end
    end

endmodule

// File: source/dcache_tags.sv
`timescale 1ns/10ps

module dcache_tags (
    input  logic                clk,
    input  logic                resetn,
    input  lsu_pkg::word_t      mem_addr,
    input  logic                fill_en,
    input  cache_pkg::way_sel_t fill_way,
    input  logic                lru_touch,
    output cache_pkg::way_sel_t hit_way,
    output cache_pkg::way_sel_t victim_way
);

    cache_pkg::way_sel_t valid_q [cache_pkg::DCACHE_SETS];
    cache_pkg::tag_t     tag_q [cache_pkg::DCACHE_SETS][cache_pkg::DCACHE_WAYS];
    logic                lru_q [cache_pkg::DCACHE_SETS];    // names the older way
    cache_pkg::index_t   idx;
    cache_pkg::tag_t     tag;

    assign idx = mem_addr[cache_pkg::TAG_LSB-1:cache_pkg::INDEX_LSB];
    assign tag = mem_addr[31:cache_pkg::TAG_LSB];

    always_comb begin
        hit_way    = '0;
        victim_way = '0;
        victim_way[lru_q[idx]] = 1'b1;
        for (int w = cache_pkg::DCACHE_WAYS - 1; w >= 0; w--) begin
            hit_way[w] = valid_q[idx][w] && (tag_q[idx][w] == tag);
            if (!valid_q[idx][w])
                victim_way = cache_pkg::way_sel_t'(1) << w;    // lowest invalid wins
        end
    end

    always_ff @(posedge clk) begin
        if (!resetn) begin
            for (int s = 0; s < cache_pkg::DCACHE_SETS; s++)
                valid_q[s] <= '0;
        end else if (fill_en) begin
            valid_q[idx] <= valid_q[idx] | fill_way;
        end
    end

    always_ff @(posedge clk) begin
        for (int w = 0; w < cache_pkg::DCACHE_WAYS; w++) begin
            if (fill_en && fill_way[w])
                tag_q[idx][w] <= tag;
        end
        if (fill_en)
            lru_q[idx] <= fill_way[0];    // way 0 used, way 1 is now older
        else if (lru_touch)
            lru_q[idx] <= hit_way[0];
    end

endmodule

// File: source/dcache_data.sv
`timescale 1ns/10ps

module dcache_data (
    input  logic                clk,
    input  lsu_pkg::word_t      mem_addr,
    input  logic                store_hit_en,
    input  cache_pkg::way_sel_t hit_way,
    input  lsu_pkg::word_t      mem_wdata,
    input  lsu_pkg::strb_t      mem_wstrb,
    input  logic                fill_en,
    input  cache_pkg::way_sel_t fill_way,
    input  lsu_pkg::word_t      mem_rdata,
    output lsu_pkg::word_t      hit_word
);

    lsu_pkg::word_t    data_q [cache_pkg::DCACHE_SETS][cache_pkg::DCACHE_WAYS];
    cache_pkg::index_t idx;

    assign idx = mem_addr[cache_pkg::TAG_LSB-1:cache_pkg::INDEX_LSB];

    always_comb begin
        hit_word = '0;
        for (int w = 0; w < cache_pkg::DCACHE_WAYS; w++) begin
            if (hit_way[w])
                hit_word = data_q[idx][w];
        end
    end

    always_ff @(posedge clk) begin
        for (int w = 0; w < cache_pkg::DCACHE_WAYS; w++) begin
            if (fill_en && fill_way[w]) begin
                data_q[idx][w] <= mem_rdata;
            end else if (store_hit_en && hit_way[w]) begin
                for (int b = 0; b < 4; b++) begin
                    if (mem_wstrb[b])
                        data_q[idx][w][8*b +: 8] <= mem_wdata[8*b +: 8];
                end
            end
        end
    end

endmodule

// File: source/load_result.sv
`timescale 1ns/10ps

module load_result (
    input  logic               clk,
    input  logic               resetn,
    input  logic               wb_take,
    input  logic               wb_use_fill,
    input  logic               wb_is_store,
    input  lsu_pkg::mem_op_e   mem_op,
    input  lsu_pkg::word_t     mem_addr,
    input  lsu_pkg::rob_num_t  mem_dest,
    input  logic               mem_misaligned,
    input  lsu_pkg::word_t     hit_word,
    input  lsu_pkg::word_t     mem_rdata,
    output logic               wb_valid,
    output logic               wb_wen,
    output lsu_pkg::rob_num_t  wb_num,
    output lsu_pkg::word_t     wb_result,
    output lsu_pkg::word_t     wb_bad_vaddr,
    output lsu_pkg::exc_code_e wb_excode,
    output logic               done_en,
    output lsu_pkg::rob_num_t  done_num
);

    lsu_pkg::word_t fill_q;
    lsu_pkg::word_t src;
    lsu_pkg::word_t ext;
    logic [7:0]     lbyte;
    logic [15:0]    lhalf;

    // read data from the cycle before, which in FILL_WRITE is the fill word
    always_ff @(posedge clk)
        fill_q <= mem_rdata;

    assign src   = wb_use_fill ? fill_q : hit_word;
    assign lbyte = src[{mem_addr[1:0], 3'b000} +: 8];
    assign lhalf = mem_addr[1] ? src[31:16] : src[15:0];

    always_comb begin
        case (mem_op)
            lsu_pkg::OP_LB:  ext = {{24{lbyte[7]}}, lbyte};
            lsu_pkg::OP_LBU: ext = {24'b0, lbyte};
            lsu_pkg::OP_LH:  ext = {{16{lhalf[15]}}, lhalf};
            lsu_pkg::OP_LHU: ext = {16'b0, lhalf};
            default:         ext = src;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!resetn) begin
            wb_valid <= 1'b0;
            wb_wen   <= 1'b0;
            done_en  <= 1'b0;
        end else begin
            wb_valid <= wb_take && (!wb_is_store || mem_misaligned);
            wb_wen   <= wb_take && !wb_is_store && !mem_misaligned;
            done_en  <= wb_take && wb_is_store && !mem_misaligned;
        end
    end

    always_ff @(posedge clk) begin
        if (wb_take) begin
            wb_num       <= mem_dest;
            wb_result    <= ext;
            wb_bad_vaddr <= mem_addr;
            if (!mem_misaligned)
                wb_excode <= lsu_pkg::EXC_NONE;
            else
                wb_excode <= wb_is_store ? lsu_pkg::EXC_STORE_ADDR : lsu_pkg::EXC_LOAD_ADDR;
        end
    end

    assign done_num = wb_num;    // one register serves both ports

endmodule

// File: source/lsu_top.sv
`timescale 1ns/10ps

module lsu_top (
    input  logic                clk,
    input  logic                resetn,
    input  logic                sel_valid,
    input  lsu_pkg::mem_op_e    sel_op,
    input  lsu_pkg::word_t      sel_base,
    input  lsu_pkg::offset_t    sel_offset,
    input  lsu_pkg::word_t      sel_store_data,
    input  lsu_pkg::rob_num_t   sel_dest,
    output logic                issue_busy,
    output logic                mem_req_valid,
    output logic                mem_req_write,
    output lsu_pkg::word_t      mem_req_addr,
    output lsu_pkg::word_t      mem_req_wdata,
    output lsu_pkg::strb_t      mem_req_wstrb,
    input  logic                mem_credit,
    input  logic                mem_rvalid,
    input  lsu_pkg::word_t      mem_rdata,
    output logic                wb_valid,
    output logic                wb_wen,
    output lsu_pkg::rob_num_t   wb_num,
    output lsu_pkg::word_t      wb_result,
    output lsu_pkg::word_t      wb_bad_vaddr,
    output lsu_pkg::exc_code_e  wb_excode,
    output logic                done_en,
    output lsu_pkg::rob_num_t   done_num
);

    logic                iss_valid;
    logic                mem_valid;
    lsu_pkg::mem_op_e    mem_op;
    lsu_pkg::word_t      mem_addr;
    lsu_pkg::word_t      mem_wdata;
    lsu_pkg::strb_t      mem_wstrb;
    lsu_pkg::rob_num_t   mem_dest;
    logic                mem_misaligned;
    cache_pkg::way_sel_t hit_way;
    cache_pkg::way_sel_t victim_way;
    cache_pkg::way_sel_t fill_way;
    logic                advance;
    logic                fill_en;
    logic                store_hit_en;
    logic                lru_touch;
    logic                wb_take;
    logic                wb_use_fill;
    logic                wb_is_store;
    lsu_pkg::word_t      hit_word;

    // memory channel payload comes straight from the mem stage
    assign mem_req_addr  = mem_addr;
    assign mem_req_wdata = mem_wdata;
    assign mem_req_wstrb = mem_wstrb;

    lsu_ctrl ctrl0 (
        .clk(clk), .resetn(resetn),
        .iss_valid(iss_valid), .mem_valid(mem_valid), .mem_op(mem_op),
        .mem_misaligned(mem_misaligned), .hit_way(hit_way), .victim_way(victim_way),
        .mem_credit(mem_credit), .mem_rvalid(mem_rvalid),
        .issue_busy(issue_busy), .advance(advance),
        .mem_req_valid(mem_req_valid), .mem_req_write(mem_req_write),
        .fill_en(fill_en), .fill_way(fill_way), .store_hit_en(store_hit_en),
        .lru_touch(lru_touch), .wb_take(wb_take), .wb_use_fill(wb_use_fill),
        .wb_is_store(wb_is_store)
    );

    lsu_agu agu0 (
        .clk(clk), .resetn(resetn), .advance(advance),
        .sel_valid(sel_valid), .sel_op(sel_op), .sel_base(sel_base),
        .sel_offset(sel_offset), .sel_store_data(sel_store_data), .sel_dest(sel_dest),
        .iss_valid(iss_valid), .mem_valid(mem_valid), .mem_op(mem_op),
        .mem_addr(mem_addr), .mem_wdata(mem_wdata), .mem_wstrb(mem_wstrb),
        .mem_dest(mem_dest), .mem_misaligned(mem_misaligned)
    );

    dcache_tags tags0 (
        .clk(clk), .resetn(resetn), .mem_addr(mem_addr),
        .fill_en(fill_en), .fill_way(fill_way), .lru_touch(lru_touch),
        .hit_way(hit_way), .victim_way(victim_way)
    );

    dcache_data data0 (
        .clk(clk), .mem_addr(mem_addr), .store_hit_en(store_hit_en), .hit_way(hit_way),
        .mem_wdata(mem_wdata), .mem_wstrb(mem_wstrb), .fill_en(fill_en),
        .fill_way(fill_way), .mem_rdata(mem_rdata), .hit_word(hit_word)
    );

    load_result res0 (
        .clk(clk), .resetn(resetn), .wb_take(wb_take), .wb_use_fill(wb_use_fill),
        .wb_is_store(wb_is_store), .mem_op(mem_op), .mem_addr(mem_addr),
        .mem_dest(mem_dest), .mem_misaligned(mem_misaligned), .hit_word(hit_word),
        .mem_rdata(mem_rdata), .wb_valid(wb_valid), .wb_wen(wb_wen), .wb_num(wb_num),
        .wb_result(wb_result), .wb_bad_vaddr(wb_bad_vaddr), .wb_excode(wb_excode),
        .done_en(done_en), .done_num(done_num)
    );

endmodule

// File: tb/mem_model.sv
`timescale 1ns/10ps

module mem_model (
    input  logic           clk,
    input  logic           resetn,
    input  logic           hold,       // keeps freed credits back
    input  logic           req_valid,
    input  logic           req_write,
    input  lsu_pkg::word_t req_addr,
    input  lsu_pkg::word_t req_wdata,
    input  lsu_pkg::strb_t req_wstrb,
    output logic           credit,
    output logic           rvalid,
    output lsu_pkg::word_t rdata
);

    lsu_pkg::word_t mem [256];
    integer         seed;
    int             pend;       // slots used, credit not yet returned
    int             rd_wait;
    logic           rd_busy;
    lsu_pkg::word_t rd_addr;
    logic           give;

    // every byte depends on the word address
    function automatic lsu_pkg::word_t init_word(int i);
        return {i[7:0] ^ 8'hc5, 8'h80 | i[6:0], ~i[7:0], i[7:0]};
    endfunction

    initial begin
        seed = 32'h39e4;
        credit = 1'b0;
        rvalid = 1'b0;
        rdata = '0;
        for (int i = 0; i < 256; i++)
            mem[i] = init_word(i);
    end

    always @(posedge clk) begin
        if (!resetn) begin
            pend    <= 0;
            rd_busy <= 1'b0;
            rvalid  <= 1'b0;
            credit  <= 1'b0;
        end else begin
            give = (pend > 0) && !hold && (($random(seed) & 3) == 0);
            credit <= give;
            pend   <= pend + (req_valid ? 1 : 0) - (give ? 1 : 0);
            rvalid <= 1'b0;
            if (req_valid && req_write) begin
                for (int b = 0; b < 4; b++) begin
                    if (req_wstrb[b])
                        mem[req_addr[9:2]][8*b +: 8] <= req_wdata[8*b +: 8];
                end
            end
            if (req_valid && !req_write) begin
                rd_busy <= 1'b1;
                rd_addr <= req_addr;
                rd_wait <= 1 + ($random(seed) & 7);
            end else if (rd_busy) begin
                if (rd_wait == 1) begin
                    rvalid  <= 1'b1;
                    rdata   <= mem[rd_addr[9:2]];
                    rd_busy <= 1'b0;
                end else begin
                    rd_wait <= rd_wait - 1;
                end
            end
        end
    end

endmodule

// File: tb/lsu_tb.sv
`timescale 1ns/10ps

module lsu_tb;

    logic clk;
    logic resetn;
    logic sel_valid;
    lsu_pkg::mem_op_e sel_op;
    lsu_pkg::word_t sel_base;
    lsu_pkg::offset_t sel_offset;
    lsu_pkg::word_t sel_store_data;
    lsu_pkg::rob_num_t sel_dest;
    logic issue_busy;
    logic mem_req_valid;
    logic mem_req_write;
    lsu_pkg::word_t mem_req_addr;
    lsu_pkg::word_t mem_req_wdata;
    lsu_pkg::strb_t mem_req_wstrb;
    logic mem_credit;
    logic mem_rvalid;
    lsu_pkg::word_t mem_rdata;
    logic wb_valid;
    logic wb_wen;
    lsu_pkg::rob_num_t wb_num;
    lsu_pkg::word_t wb_result;
    lsu_pkg::word_t wb_bad_vaddr;
    lsu_pkg::exc_code_e wb_excode;
    logic done_en;
    lsu_pkg::rob_num_t done_num;
    logic hold;

    // stimulus table, one entry per row
    lsu_pkg::mem_op_e t_op[$];
    lsu_pkg::word_t t_base[$];
    lsu_pkg::offset_t t_off[$];
    lsu_pkg::word_t t_data[$];
    lsu_pkg::exc_code_e t_exc[$];
    int t_rd[$];      // read requests expected, -1 when not checked
    bit t_hold[$];

    // scoreboard keyed by destination
    bit pending[32];
    bit exp_store[32];
    lsu_pkg::exc_code_e exp_exc[32];
    lsu_pkg::word_t exp_addr[32];
    lsu_pkg::word_t exp_val[32];

    lsu_pkg::word_t gmem[256];
    lsu_pkg::word_t wq_addr[$];
    lsu_pkg::word_t wq_data[$];
    lsu_pkg::strb_t wq_strb[$];

    int value_errs;
    int proto_errs;
    int reads;
    int credits;
    int busy_run;
    bit busy_seen;

    lsu_top dut0 (.*);

    mem_model mem0 (
        .clk(clk), .resetn(resetn), .hold(hold),
        .req_valid(mem_req_valid), .req_write(mem_req_write), .req_addr(mem_req_addr),
        .req_wdata(mem_req_wdata), .req_wstrb(mem_req_wstrb),
        .credit(mem_credit), .rvalid(mem_rvalid), .rdata(mem_rdata)
    );

    always #50 clk = !clk;

    function automatic lsu_pkg::word_t load_value(lsu_pkg::mem_op_e op, lsu_pkg::word_t a);
        lsu_pkg::word_t w;
        logic [7:0] b;
        logic [15:0] h;
        w = gmem[a[9:2]];
        b = w >> (8 * a[1:0]);
        h = w >> (8 * a[1:0]);
        case (op)
            lsu_pkg::OP_LB:  return {{24{b[7]}}, b};
            lsu_pkg::OP_LBU: return {24'b0, b};
            lsu_pkg::OP_LH:  return {{16{h[15]}}, h};
            lsu_pkg::OP_LHU: return {16'b0, h};
            default:         return w;
        endcase
    endfunction

    // golden write, and the write request the memory should see
    task automatic apply_store(lsu_pkg::mem_op_e op, lsu_pkg::word_t a, lsu_pkg::word_t d);
        lsu_pkg::strb_t s;
        lsu_pkg::word_t lanes;
        int nbytes;
        int lane;
        case (op)
            lsu_pkg::OP_SB: nbytes = 1;
            lsu_pkg::OP_SH: nbytes = 2;
            default:        nbytes = 4;
        endcase
        s = '0;
        lanes = '0;
        // byte k of the data lands in the lane at offset plus k
        for (int k = 0; k < nbytes; k++) begin
            lane = a[1:0] + k;
            s[lane] = 1'b1;
            lanes[8*lane +: 8] = d[8*k +: 8];
            gmem[a[9:2]][8*lane +: 8] = d[8*k +: 8];
        end
        wq_addr.push_back(a);
        wq_data.push_back(lanes);
        wq_strb.push_back(s);
    endtask

    task automatic give_up(string what);
        $display("timeout while waiting for %s at %0t", what, $time);
        $display("errors: %0d wrong values, %0d protocol", value_errs, proto_errs);
        $display("TEST FAILED");
        $finish;
    endtask

    task automatic drain_all();
        int n;
        bit busy;
        n = 0;
        sel_valid <= 1'b0;
        forever begin
            @(negedge clk);
            busy = 0;
            for (int d = 0; d < 32; d++)
                busy |= pending[d];
            if (!busy)
                break;
            n++;
            if (n > 500)
                give_up("outstanding results");
        end
        @(posedge clk);
    endtask

    task automatic present_row(int i);
        lsu_pkg::word_t a;
        int off_s;
        int r0;
        int n;
        int dest;
        dest = i % 32;
        off_s = $signed(t_off[i]);
        a = t_base[i] + off_s;
        if (t_rd[i] >= 0 || pending[dest])
            drain_all();
        r0 = reads;
        exp_store[dest] = t_op[i] inside {lsu_pkg::OP_SB, lsu_pkg::OP_SH, lsu_pkg::OP_SW};
        exp_exc[dest] = t_exc[i];
        exp_addr[dest] = a;
        exp_val[dest] = load_value(t_op[i], a);
        if (exp_store[dest] && t_exc[i] == lsu_pkg::EXC_NONE)
            apply_store(t_op[i], a, t_data[i]);
        pending[dest] = 1'b1;
        if (t_hold[i])
            hold <= 1'b1;
        sel_valid <= 1'b1;
        sel_op <= t_op[i];
        sel_base <= t_base[i];
        sel_offset <= t_off[i];
        sel_store_data <= t_data[i];
        sel_dest <= lsu_pkg::rob_num_t'(dest);
        n = 0;
        forever begin
            @(negedge clk);
            if (!issue_busy)
                break;
            n++;
            if (n > 500)
                give_up("issue slot");
        end
        @(posedge clk);    // row taken here
        if (t_rd[i] >= 0) begin
            drain_all();
            if (reads - r0 != t_rd[i]) begin
                $display("[FAIL] %0t: row %0d made %0d read requests, expected %0d",
                         $time, i, reads - r0, t_rd[i]);
                value_errs++;
            end
        end
    endtask

    task automatic add_row(lsu_pkg::mem_op_e op, lsu_pkg::word_t base, lsu_pkg::offset_t off,
                           lsu_pkg::word_t data, lsu_pkg::exc_code_e exc, int rd, bit hl);
        t_op.push_back(op);
        t_base.push_back(base);
        t_off.push_back(off);
        t_data.push_back(data);
        t_exc.push_back(exc);
        t_rd.push_back(rd);
        t_hold.push_back(hl);
    endtask

    task automatic build_table();
        add_row(lsu_pkg::OP_LW, 'h100, 0, 0, lsu_pkg::EXC_NONE, 1, 0);
        add_row(lsu_pkg::OP_LW, 'h0f8, 8, 0, lsu_pkg::EXC_NONE, 0, 0);
        add_row(lsu_pkg::OP_SB, 'h200, 0, 'hffffff81, lsu_pkg::EXC_NONE, -1, 0);
        add_row(lsu_pkg::OP_SB, 'h200, 1, 'h0000007f, lsu_pkg::EXC_NONE, -1, 0);
        add_row(lsu_pkg::OP_SB, 'h200, 2, 'h123456c3, lsu_pkg::EXC_NONE, -1, 0);
        add_row(lsu_pkg::OP_SB, 'h200, 3, 'h00000012, lsu_pkg::EXC_NONE, -1, 0);
        add_row(lsu_pkg::OP_LW, 'h200, 0, 0, lsu_pkg::EXC_NONE, 1, 0);    // no allocate
        add_row(lsu_pkg::OP_SH, 'h204, 0, 'hffff8001, lsu_pkg::EXC_NONE, -1, 0);
        add_row(lsu_pkg::OP_SH, 'h204, 2, 'h00007ffe, lsu_pkg::EXC_NONE, -1, 0);
        add_row(lsu_pkg::OP_LW, 'h204, 0, 0, lsu_pkg::EXC_NONE, -1, 0);
        add_row(lsu_pkg::OP_SW, 'h208, 0, 'hdeadbeef, lsu_pkg::EXC_NONE, -1, 0);
        add_row(lsu_pkg::OP_LW, 'h208, 0, 0, lsu_pkg::EXC_NONE, -1, 0);
        for (int k = 0; k < 4; k++) begin
            add_row(lsu_pkg::OP_LB, 'h200, k, 0, lsu_pkg::EXC_NONE, -1, 0);
            add_row(lsu_pkg::OP_LBU, 'h200, k, 0, lsu_pkg::EXC_NONE, -1, 0);
        end
        for (int k = 0; k < 4; k += 2) begin
            add_row(lsu_pkg::OP_LH, 'h204, k, 0, lsu_pkg::EXC_NONE, -1, 0);
            add_row(lsu_pkg::OP_LHU, 'h204, k, 0, lsu_pkg::EXC_NONE, -1, 0);
        end
        add_row(lsu_pkg::OP_SB, 'h200, 1, 'h00000090, lsu_pkg::EXC_NONE, -1, 0);    // store hit
        add_row(lsu_pkg::OP_LB, 'h200, 1, 0, lsu_pkg::EXC_NONE, 0, 0);
        add_row(lsu_pkg::OP_LHU, 'h200, 0, 0, lsu_pkg::EXC_NONE, 0, 0);
        add_row(lsu_pkg::OP_LH, 'h200, 1, 0, lsu_pkg::EXC_LOAD_ADDR, 0, 0);
        add_row(lsu_pkg::OP_SH, 'h200, 3, 'h5555, lsu_pkg::EXC_STORE_ADDR, 0, 0);
        add_row(lsu_pkg::OP_LW, 'h200, 2, 0, lsu_pkg::EXC_LOAD_ADDR, 0, 0);
        add_row(lsu_pkg::OP_SW, 'h200, 1, 'h5555, lsu_pkg::EXC_STORE_ADDR, 0, 0);
        // A, B and C share set 16
        add_row(lsu_pkg::OP_LW, 'h040, 0, 0, lsu_pkg::EXC_NONE, 1, 0);
        add_row(lsu_pkg::OP_LW, 'h140, 0, 0, lsu_pkg::EXC_NONE, 1, 0);
        add_row(lsu_pkg::OP_LW, 'h040, 0, 0, lsu_pkg::EXC_NONE, 0, 0);
        add_row(lsu_pkg::OP_LW, 'h250, 'h1fff0, 0, lsu_pkg::EXC_NONE, 1, 0);
        add_row(lsu_pkg::OP_LW, 'h040, 0, 0, lsu_pkg::EXC_NONE, 0, 0);
        add_row(lsu_pkg::OP_LW, 'h140, 0, 0, lsu_pkg::EXC_NONE, 1, 0);
        for (int k = 0; k < 6; k++)
            add_row(lsu_pkg::OP_SW, 'h300, 4 * k, 'ha0b0c000 + k, lsu_pkg::EXC_NONE, -1, k == 0);
        for (int k = 0; k < 6; k++)
            add_row(lsu_pkg::OP_LW, 'h300, 4 * k, 0, lsu_pkg::EXC_NONE, -1, 0);
    endtask

    // credits come back once the unit has stalled for a while
    always @(negedge clk) begin
        if (issue_busy) begin
            if (hold)
                busy_seen = 1'b1;
            busy_run++;
        end else begin
            busy_run = 0;
        end
        if (busy_run >= 20)
            hold <= 1'b0;
    end

    always @(negedge clk) begin
        if (!resetn) begin
            credits = cache_pkg::MEM_CREDITS;
        end else begin
            if (mem_req_valid && credits == 0) begin
                $display("request sent with no credit left at %0t", $time);
                proto_errs++;
            end
            credits = credits + mem_credit - mem_req_valid;
            if (mem_req_valid && !mem_req_write)
                reads++;
            if (mem_req_valid && mem_req_write) begin
                if (wq_addr.size() == 0) begin
                    $display("unexpected write request at %0t", $time);
                    proto_errs++;
                end else if (mem_req_addr != wq_addr[0] || mem_req_wstrb != wq_strb[0]
                             || ((mem_req_wdata ^ wq_data[0])
                                 & {{8{wq_strb[0][3]}}, {8{wq_strb[0][2]}},
                                    {8{wq_strb[0][1]}}, {8{wq_strb[0][0]}}}) != 0) begin
                    $display("[FAIL] %0t: write %h/%h/%b, expected %h/%h/%b", $time,
                             mem_req_addr, mem_req_wdata, mem_req_wstrb,
                             wq_addr[0], wq_data[0], wq_strb[0]);
                    value_errs++;
                end
                if (wq_addr.size() != 0) begin
                    void'(wq_addr.pop_front());
                    void'(wq_data.pop_front());
                    void'(wq_strb.pop_front());
                end
            end
            if (done_en) begin
                if (!pending[done_num] || !exp_store[done_num]
                    || exp_exc[done_num] != lsu_pkg::EXC_NONE) begin
                    $display("unexpected store completion for %0d at %0t", done_num, $time);
                    proto_errs++;
                end
                pending[done_num] = 1'b0;
            end
            if (wb_valid) begin
                if (!pending[wb_num]) begin
                    $display("unexpected write-back for %0d at %0t", wb_num, $time);
                    proto_errs++;
                end else if (wb_excode != exp_exc[wb_num]) begin
                    $display("[FAIL] %0t: dest %0d excode %0d, expected %0d", $time,
                             wb_num, wb_excode, exp_exc[wb_num]);
                    value_errs++;
                end else if (wb_excode != lsu_pkg::EXC_NONE) begin
                    if (wb_bad_vaddr != exp_addr[wb_num] || wb_wen) begin
                        $display("[FAIL] %0t: dest %0d bad address %h wen %b, expected %h",
                                 $time, wb_num, wb_bad_vaddr, wb_wen, exp_addr[wb_num]);
                        value_errs++;
                    end
                end else if (exp_store[wb_num] || !wb_wen || wb_result != exp_val[wb_num]) begin
                    $display("[FAIL] %0t: dest %0d result %h wen %b, expected %h", $time,
                             wb_num, wb_result, wb_wen, exp_val[wb_num]);
                    value_errs++;
                end
                pending[wb_num] = 1'b0;
            end
        end
    end

    initial begin
        clk = 1'b0;
        resetn = 1'b0;
        hold = 1'b0;
        sel_valid = 1'b0;
        sel_op = lsu_pkg::OP_LW;
        sel_base = '0;
        sel_offset = '0;
        sel_store_data = '0;
        sel_dest = '0;
        value_errs = 0;
        proto_errs = 0;
        reads = 0;
        busy_run = 0;
        busy_seen = 0;
        for (int i = 0; i < 256; i++)
            gmem[i] = {i[7:0] ^ 8'hc5, 8'h80 | i[6:0], ~i[7:0], i[7:0]};
        build_table();
        repeat (4) @(posedge clk);
        @(negedge clk);
        if (issue_busy || wb_valid || wb_wen || done_en || mem_req_valid) begin
            $display("outputs not low during reset");
            proto_errs++;
        end
        @(posedge clk);
        resetn <= 1'b1;
        @(posedge clk);
        for (int i = 0; i < t_op.size(); i++)
            present_row(i);
        drain_all();
        if (wq_addr.size() != 0) begin
            $display("%0d write requests never reached memory", wq_addr.size());
            proto_errs++;
        end
        if (!busy_seen) begin
            $display("issue_busy never rose while credits were held back");
            proto_errs++;
        end
        $display("errors: %0d wrong values, %0d protocol", value_errs, proto_errs);
        if (value_errs == 0 && proto_errs == 0)
            $display("TEST PASSED");
        else
            $display("TEST FAILED");
        $finish;
    end

endmodule

// File: verilog.f
source/lsu_pkg.sv
source/cache_pkg.sv
source/lsu_agu.sv
source/lsu_ctrl.sv
source/dcache_tags.sv
source/dcache_data.sv
source/load_result.sv
source/lsu_top.sv
tb/mem_model.sv
tb/lsu_tb.sv
